// ==== bench/regMachineTests.txt ====
// seed followed by the 17 expected write-back words in hex
// words 0 to 15 go to r0 to r15 and the last word is r15 again after the OR
01 0001 0002 0003 0005 0008 000d 0015 0022 0037 0059 0090 00e9 0179 0262 03db 063d 063d
00 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
ff 00ff 01fe 02fd 04fb 07f8 0cf3 14eb 21de 36c9 58a7 8f70 e817 7787 5f9e d725 36c3 36c3
80 0080 0100 0180 0280 0400 0680 0a80 1100 1b80 2c80 4800 7480 bc80 3100 ed80 1e80 1e80
5a 005a 00b4 010e 01c2 02d0 0492 0762 0bf4 1356 1f4a 32a0 51ea 848a d674 5afe 3172 3172
37 0037 006e 00a5 0113 01b8 02cb 0483 074e 0bd1 131f 1ef0 320f 50ff 830e d40d 571b 571b

// ==== project.f ====
source/regMachinePkg.sv
source/programSequencer.sv
source/operandExecute.sv
source/registerWriteback.sv
source/regMachineTop.sv
bench/writebackChecker.sv
bench/regMachineBench.sv

// ==== runSim.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
logFile=build/sim.log
mkdir -p build || exit 1
verilator --binary --timing -Mdir build --top-module regMachineBench -f project.f \
	|| { echo "verilator build error"; exit 1; }
./build/VregMachineBench > "$logFile" 2>&1 || echo "simulator exited with an error"
cat "$logFile"
grep -q "Simulation failed" "$logFile" && exit 1
grep -q "Simulation passed" "$logFile" || exit 1
exit 0

// ==== bench/regMachineBench.sv ====
`timescale 1ns/1ns
`default_nettype none

module regMachineBench;

	localparam string testsFile = "bench/regMachineTests.txt";

	// seed plus the write-back words on one line
	localparam int fieldCount = regMachinePkg::programLength + 1;

	logic clk;
	logic rst;
	logic start;
	logic [regMachinePkg::immWidth-1:0] seed;
	logic busy;
	regMachinePkg::resultWord wb;

	int valueErrors;
	int protocolErrors;
	int runsChecked;
	int pendingWords;
	int benchErrors;
	int cycleCount;
	int cycleLimit;

	logic [regMachinePkg::immWidth-1:0] seeds [$];
	logic [regMachinePkg::dataWidth-1:0] expectedAll [$];

	regMachineTop i_dut (
		.clk   (clk),
		.rst   (rst),
		.start (start),
		.seed  (seed),
		.busy  (busy),
		.wb    (wb)
	);

	writebackChecker i_checker (
		.clk            (clk),
		.rst            (rst),
		.start          (start),
		.seed           (seed),
		.busy           (busy),
		.wb             (wb),
		.valueErrors    (valueErrors),
		.protocolErrors (protocolErrors),
		.runsChecked    (runsChecked),
		.pendingWords   (pendingWords)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	//////////////////////////////
	// tests file
	//////////////////////////////

	task automatic readTests();
		int fd;
		int count;
		int lineNo;
		string line;
		logic [regMachinePkg::dataWidth-1:0] fields [fieldCount];

		fd = $fopen(testsFile, "r");
		if (fd == 0) begin
			$display("could not open the tests file %s", testsFile);
			benchErrors++;
			return;
		end
		lineNo = 0;
		while ($fgets(line, fd) != 0) begin
			lineNo++;
			if (line.substr(0, 1) == "//") begin
				continue;
			end
			count = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
				fields[0], fields[1], fields[2], fields[3], fields[4], fields[5],
				fields[6], fields[7], fields[8], fields[9], fields[10], fields[11],
				fields[12], fields[13], fields[14], fields[15], fields[16], fields[17]);
			// blank line
			if (count <= 0) begin
				continue;
			end
			if (count != fieldCount || (fields[0] >> regMachinePkg::immWidth) != '0) begin
				$display("line %0d of the tests file does not hold a seed and %0d words",
					lineNo, regMachinePkg::programLength);
				benchErrors++;
				continue;
			end
			seeds.push_back(fields[0][regMachinePkg::immWidth-1:0]);
			for (int k = 1; k < fieldCount; k++) begin
				expectedAll.push_back(fields[k]);
			end
		end
		$fclose(fd);
	endtask

	//////////////////////////////
	// stimulus
	//////////////////////////////

	// called 1 ns after an edge and returns 1 ns after one
	task automatic runTest(input int t);
		int gap;

		for (int w = 0; w < regMachinePkg::programLength; w++) begin
			i_checker.queueWord(expectedAll[t * regMachinePkg::programLength + w]);
		end
		start = 1'b1;
		seed = seeds[t];
		@(posedge clk);
		#1;
		start = 1'b0;
		// a second start in mid-run with another seed must be dropped
		repeat (2) begin
			@(posedge clk);
			#1;
		end
		start = 1'b1;
		seed = ~seeds[t];
		@(posedge clk);
		#1;
		start = 1'b0;
		seed = '0;
		while (busy) begin
			@(posedge clk);
			#1;
		end
		gap = $urandom_range(5, 0);
		repeat (gap) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic printCounts();
		$display("tests %0d, runs checked %0d, value errors %0d, protocol errors %0d, other errors %0d",
			seeds.size(), runsChecked, valueErrors, protocolErrors, benchErrors);
	endtask

	initial begin
		void'($urandom(32'h7890));
		rst = 1'b1;
		start = 1'b0;
		seed = '0;
		benchErrors = 0;
		cycleLimit = 0;
		readTests();
		if (seeds.size() == 0) begin
			$display("the tests file holds no tests");
			benchErrors++;
		end
		cycleLimit = seeds.size() * (regMachinePkg::programLength + 2 + 5) + 50;
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;
		// idle after reset, wb and busy must stay low
		repeat (4) begin
			@(posedge clk);
			#1;
		end
		for (int t = 0; t < seeds.size(); t++) begin
			runTest(t);
		end
		repeat (3) begin
			@(posedge clk);
			#1;
		end
		if (runsChecked != seeds.size()) begin
			$display("only %0d of %0d runs completed", runsChecked, seeds.size());
			benchErrors++;
		end
		if (pendingWords != 0) begin
			$display("%0d expected words were never used", pendingWords);
			benchErrors++;
		end
		printCounts();
		if (valueErrors + protocolErrors + benchErrors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	// limit from the tests' length plus a margin
	always @(posedge clk) begin
		if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
			$display("the run did not finish within %0d cycles", cycleLimit);
			printCounts();
			$display("Simulation failed");
			$finish;
		end else begin
			cycleCount++;
		end
	end

	initial begin
		cycleCount = 0;
	end

endmodule

`default_nettype wire

// ==== bench/writebackChecker.sv ====
`timescale 1ns/1ns
`default_nettype none

module writebackChecker (
	input  logic clk,
	input  logic rst,
	input  logic start,
	input  logic [regMachinePkg::immWidth-1:0] seed,
	input  logic busy,
	input  regMachinePkg::resultWord wb,
	output int valueErrors,
	output int protocolErrors,
	output int runsChecked,
	output int pendingWords
);

	// phase of the 17th write-back, counted in edges from the start edge
	localparam int lastPhase = regMachinePkg::programLength;

	// expected data words, pushed by the bench ahead of each start
	logic [regMachinePkg::dataWidth-1:0] expectQueue [$];

	// the run in progress
	logic [regMachinePkg::dataWidth-1:0] runWords [regMachinePkg::programLength];
	logic [regMachinePkg::immWidth-1:0] runSeed;
	int runCount;

	// -1 while idle, else edges since the start edge
	int phase;

	task automatic queueWord(input logic [regMachinePkg::dataWidth-1:0] word);
		expectQueue.push_back(word);
	endtask

	// write-backs 0 to 15 land in r0 to r15, the closing OR lands in r15 again
	function automatic logic [regMachinePkg::regAddrWidth-1:0] expectedAddr(input int index);
		if (index >= regMachinePkg::numRegs) begin
			return regMachinePkg::regAddrWidth'(regMachinePkg::numRegs - 1);
		end
		return regMachinePkg::regAddrWidth'(index);
	endfunction

	//////////////////////////////
	// per write-back checks
	//////////////////////////////

	task automatic checkWriteback(input int index);
		if (wb.addr !== expectedAddr(index)) begin
			$display("error: wb.addr in run %0d write-back %0d: got %h, expected %h",
				runCount, index, wb.addr, expectedAddr(index));
			valueErrors++;
		end
		if (wb.data !== runWords[index]) begin
			$display("error: wb.data in run %0d write-back %0d: got %h, expected %h",
				runCount, index, wb.data, runWords[index]);
			valueErrors++;
		end
		// r0 is the seed zero-extended
		if (index == 0 && wb.data !== regMachinePkg::dataWidth'(runSeed)) begin
			$display("error: wb.data in run %0d write-back 0: got %h, expected seed %h",
				runCount, wb.data, regMachinePkg::dataWidth'(runSeed));
			valueErrors++;
		end
		// r15 | r15 leaves r15 as it was
		if (index == lastPhase - 1 && wb.data !== runWords[index - 1]) begin
			$display("error: wb.data in run %0d final write-back: got %h, expected %h",
				runCount, wb.data, runWords[index - 1]);
			valueErrors++;
		end
	endtask

	task automatic acceptRun();
		phase = 0;
		runCount++;
		runSeed = seed;
		if (expectQueue.size() < regMachinePkg::programLength) begin
			$display("start accepted for run %0d with only %0d expected words queued",
				runCount, expectQueue.size());
			protocolErrors++;
		end
		for (int i = 0; i < regMachinePkg::programLength; i++) begin
			if (expectQueue.size() != 0) begin
				runWords[i] = expectQueue.pop_front();
			end else begin
				runWords[i] = '0;
			end
		end
	endtask

	//////////////////////////////
	// cycle model
	//////////////////////////////

	always @(posedge clk) begin : monitor
		logic expBusy;
		logic expValid;

		pendingWords = expectQueue.size();
		if (rst) begin
			phase = -1;
			runCount = 0;
			valueErrors = 0;
			protocolErrors = 0;
			runsChecked = 0;
		end else begin
			// busy from the start edge on, wb one edge later, both through phase 17
			expBusy = (phase >= 0);
			expValid = (phase >= 1);
			if (busy !== expBusy) begin
				$display("error: busy in run %0d phase %0d: got %h, expected %h",
					runCount, phase, busy, expBusy);
				protocolErrors++;
			end
			if (wb.valid !== expValid) begin
				$display("error: wb.valid in run %0d phase %0d: got %h, expected %h",
					runCount, phase, wb.valid, expValid);
				protocolErrors++;
			end else if (expValid) begin
				checkWriteback(phase - 1);
			end

			// a start counts only in a cycle where busy is low
			if (phase >= 0) begin
				if (phase == lastPhase) begin
					phase = -1;
					runsChecked++;
				end else begin
					phase++;
				end
			end else if (start) begin
				acceptRun();
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/regMachineTop.sv ====
`timescale 1ns/1ns
`default_nettype none

module regMachineTop (
	input  logic clk,
	input  logic rst,
	input  logic start,
	input  logic [regMachinePkg::immWidth-1:0] seed,
	output logic busy,
	output regMachinePkg::resultWord wb
);

	regMachinePkg::ctrlWord ctrl;

	logic [regMachinePkg::regAddrWidth-1:0] readAddrA;
	logic [regMachinePkg::regAddrWidth-1:0] readAddrB;
	logic [regMachinePkg::dataWidth-1:0] readDataA;
	logic [regMachinePkg::dataWidth-1:0] readDataB;

	// decode
	programSequencer i_sequencer (
		.clk   (clk),
		.rst   (rst),
		.start (start),
		.seed  (seed),
		.busy  (busy),
		.ctrl  (ctrl)
	);

	// execute, its result register drives the write-back bus directly
	operandExecute i_execute (
		.clk       (clk),
		.rst       (rst),
		.ctrl      (ctrl),
		.readAddrA (readAddrA),
		.readAddrB (readAddrB),
		.readDataA (readDataA),
		.readDataB (readDataB),
		.result    (wb)
	);

	// result
	registerWriteback i_regFile (
		.clk       (clk),
		.result    (wb),
		.readAddrA (readAddrA),
		.readAddrB (readAddrB),
		.readDataA (readDataA),
		.readDataB (readDataB)
	);

endmodule

`default_nettype wire

// ==== source/registerWriteback.sv ====
`timescale 1ns/1ns
`default_nettype none

module registerWriteback (
	input  logic clk,
	input  regMachinePkg::resultWord result,
	input  logic [regMachinePkg::regAddrWidth-1:0] readAddrA,
	input  logic [regMachinePkg::regAddrWidth-1:0] readAddrB,
	output logic [regMachinePkg::dataWidth-1:0] readDataA,
	output logic [regMachinePkg::dataWidth-1:0] readDataB
);

	// r0 to r15
	logic [regMachinePkg::dataWidth-1:0] regs [regMachinePkg::numRegs];

	//////////////////////////////
	// write port
	//////////////////////////////

	// r0 is always loaded by step 0 before any step reads it
	always_ff @(posedge clk) begin
		if (result.valid) begin
			regs[result.addr] <= result.data;
		end
	end

	//////////////////////////////
	// read ports
	//////////////////////////////

	// asynchronous, execute adds forwarding for the result still in flight
	assign readDataA = regs[readAddrA];
	assign readDataB = regs[readAddrB];

endmodule

`default_nettype wire

// ==== source/operandExecute.sv ====
`timescale 1ns/1ns
`default_nettype none

module operandExecute (
	input  logic clk,
	input  logic rst,
	input  regMachinePkg::ctrlWord ctrl,
	output logic [regMachinePkg::regAddrWidth-1:0] readAddrA,
	output logic [regMachinePkg::regAddrWidth-1:0] readAddrB,
	input  logic [regMachinePkg::dataWidth-1:0] readDataA,
	input  logic [regMachinePkg::dataWidth-1:0] readDataB,
	output regMachinePkg::resultWord result
);

	logic [regMachinePkg::dataWidth-1:0] operandA;
	logic [regMachinePkg::dataWidth-1:0] operandB;
	logic [regMachinePkg::dataWidth-1:0] immValue;
	logic [regMachinePkg::dataWidth-1:0] aluValue;
	logic [regMachinePkg::dataWidth-1:0] nextData;
	logic forwardA;
	logic forwardB;

	//////////////////////////////
	// operand fetch
	//////////////////////////////

	assign readAddrA = ctrl.readRegA;
	assign readAddrB = ctrl.readRegB;

	// the previous result is still in our own register, not yet in the file
	assign forwardA = result.valid && (result.addr == ctrl.readRegA);
	assign forwardB = result.valid && (result.addr == ctrl.readRegB);

	assign operandA = forwardA ? result.data : readDataA;
	assign operandB = forwardB ? result.data : readDataB;

	//////////////////////////////
	// operation
	//////////////////////////////

	assign immValue = regMachinePkg::dataWidth'(ctrl.imm);

	// add wraps modulo 2^dataWidth
	always_comb begin
		if (ctrl.op == regMachinePkg::opOr) begin
			aluValue = operandA | operandB;
		end else begin
			aluValue = operandA + operandB;
		end
	end

	// immediate steps are plain loads, op has no effect there
	assign nextData = ctrl.selectImm ? immValue : aluValue;

	//////////////////////////////
	// result register
	//////////////////////////////

	always_ff @(posedge clk) begin
		result.addr <= ctrl.loadReg;
		result.data <= nextData;
		if (rst) begin
			result.valid <= 1'b0;
		end else begin
			result.valid <= ctrl.valid;
		end
	end

endmodule

`default_nettype wire

// ==== source/programSequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

module programSequencer (
	input  logic clk,
	input  logic rst,
	input  logic start,
	input  logic [regMachinePkg::immWidth-1:0] seed,
	output logic busy,
	output regMachinePkg::ctrlWord ctrl
);

	// step currently presented on ctrl
	logic [regMachinePkg::stepWidth-1:0] stepCount;
	logic [regMachinePkg::stepWidth-1:0] nextStep;

	// counts down the two instructions still in flight after the last issue
	logic [1:0] drainCount;

	logic accepted;
	logic lastIssued;

	// control word for one program step
	function automatic regMachinePkg::ctrlWord decodeStep(
		input logic [regMachinePkg::stepWidth-1:0] step,
		input logic [regMachinePkg::immWidth-1:0] imm
	);
		regMachinePkg::ctrlWord word;
		logic [regMachinePkg::stepWidth-1:0] prevOne;
		logic [regMachinePkg::stepWidth-1:0] prevTwo;

		prevOne = step - 1'b1;
		prevTwo = step - 2'd2;
		word = '0;
		word.valid = 1'b1;
		case (step)
			'0: begin
				// r0 = seed
				word.selectImm = 1'b1;
				word.op = regMachinePkg::opAdd;
				word.loadReg = '0;
				word.readRegA = '0;
				word.readRegB = '0;
				word.imm = imm;
			end
			regMachinePkg::lastStep: begin
				// r15 = r15 | r15
				word.selectImm = 1'b0;
				word.op = regMachinePkg::opOr;
				word.loadReg = '1;
				word.readRegA = '1;
				word.readRegB = '1;
			end
			default: begin
				// rn = r(n-1) + r(n-2), step 1 reads r0 twice
				word.selectImm = 1'b0;
				word.op = regMachinePkg::opAdd;
				word.loadReg = step[regMachinePkg::regAddrWidth-1:0];
				word.readRegA = prevOne[regMachinePkg::regAddrWidth-1:0];
				if (step == 1) begin
					word.readRegB = '0;
				end else begin
					word.readRegB = prevTwo[regMachinePkg::regAddrWidth-1:0];
				end
			end
		endcase
		return word;
	endfunction

	// a start while busy is dropped along with its seed
	assign accepted = start && !busy;
	assign nextStep = stepCount + 1'b1;

	// the final step goes out at the next edge
	assign lastIssued = ctrl.valid && (nextStep == regMachinePkg::lastStep);

	always_ff @(posedge clk) begin
		if (rst) begin
			stepCount <= '0;
			ctrl <= '0;
			busy <= 1'b0;
			drainCount <= '0;
		end else begin
			if (accepted) begin
				// the seed is captured straight into the step 0 word
				stepCount <= '0;
				ctrl <= decodeStep('0, seed);
				busy <= 1'b1;
			end else if (ctrl.valid) begin
				if (stepCount == regMachinePkg::lastStep) begin
					ctrl <= '0;
				end else begin
					stepCount <= nextStep;
					ctrl <= decodeStep(nextStep, '0);
				end
			end

			// busy drops at the edge that writes the last result
			if (lastIssued) begin
				drainCount <= 2'd2;
			end else if (drainCount != '0) begin
				drainCount <= drainCount - 1'b1;
				if (drainCount == 2'd1) begin
					busy <= 1'b0;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/regMachinePkg.sv ====
`default_nettype none

package regMachinePkg;

	//////////////////////////////
	// widths
	//////////////////////////////

	// register and result width, sums wrap at this width
	localparam int dataWidth = 16;

	// sixteen registers r0 to r15
	localparam int regAddrWidth = 4;
	localparam int numRegs = 2 ** regAddrWidth;

	// seed and immediate width, zero-extended to dataWidth on load
	localparam int immWidth = 8;

	//////////////////////////////
	// program
	//////////////////////////////

	// steps 0 to 16
	localparam int programLength = 17;
	localparam int stepWidth = $clog2(programLength);
	localparam logic [stepWidth-1:0] lastStep = stepWidth'(programLength - 1);

	// operation codes
	localparam logic opAdd = 1'b0;
	localparam logic opOr = 1'b1;

	//////////////////////////////
	// stage words
	//////////////////////////////

	// decode to execute
	typedef struct packed {
		logic valid;
		logic selectImm;
		logic op;
		logic [regAddrWidth-1:0] loadReg;
		logic [regAddrWidth-1:0] readRegA;
		logic [regAddrWidth-1:0] readRegB;
		logic [immWidth-1:0] imm;
	} ctrlWord;

	// execute to result, also the write-back bus at the top
	typedef struct packed {
		logic valid;
		logic [regAddrWidth-1:0] addr;
		logic [dataWidth-1:0] data;
	} resultWord;

endpackage

`default_nettype wire
